// ==== verilog/pcie_axi_pkg.sv ====
package pcie_axi_pkg;

  // One decoded memory request as delivered by the PCIe target front end.
  typedef struct packed {
    logic [2:0]  bar_hit;
    logic [31:0] pcie_address;
    logic [3:0]  byte_enable;
    logic        write_readn;
    logic        phys_func;
    logic [31:0] write_data;
  } mem_req_t;

  // A write after BAR translation, ready for the AXI4-Lite master.
  typedef struct packed {
    logic [31:0] addr;
    logic [3:0]  strb;
    logic [31:0] data;
  } axi_wr_req_t;

  // Six BAR windows. Index i holds the AXI base of BAR i.
  typedef logic [5:0][31:0] bar_base_t;

  // Window size per BAR, given as the number of PCIe address bits that pass through.
  typedef logic [5:0][4:0] bar_size_t;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;
  localparam logic [1:0] RESP_DECERR = 2'b11;

endpackage

// ==== verilog/bar_request_decoder.sv ====
`timescale 1ns/100ps

module bar_request_decoder
  import pcie_axi_pkg::*;
#(
  parameter bar_base_t BAR_BASE = '0,
  parameter bar_size_t BAR_SIZE = {6{5'd12}}
) (
  input  logic        m_axi_aclk,
  input  logic        m_axi_aresetn,

  input  mem_req_t    mem_req,
  input  logic        mem_req_valid,
  output logic        mem_req_ready,

  output axi_wr_req_t push_req,
  output logic        push_valid,
  input  logic        push_ready,

  output logic [15:0] drop_count
);

  logic running;     // Set one cycle after reset is released.
  logic accept;
  logic is_drop;
  logic [31:0] axi_addr;

  // Upper bits come from the window base, lower bits from the PCIe address.
  function automatic logic [31:0] translate(input logic [2:0]  bar,
                                            input logic [31:0] pcie_addr);
    logic [31:0] base;
    logic [4:0]  size;
    logic [31:0] addr;
    addr = '0;
    if (bar > 3'd5) begin
      return addr;
    end
    base = BAR_BASE[bar];
    size = BAR_SIZE[bar];
    for (int b = 2; b < 32; b++) begin
      addr[b] = (b >= size) ? base[b] : pcie_addr[b];
    end
    return addr;
  endfunction

  assign mem_req_ready = running && (!push_valid || push_ready);
  assign accept        = mem_req_valid && mem_req_ready;
  assign is_drop       = !mem_req.write_readn || (mem_req.bar_hit > 3'd5);
  assign axi_addr      = translate(mem_req.bar_hit, mem_req.pcie_address);

  always_ff @(posedge m_axi_aclk) begin
    if (!m_axi_aresetn) begin
      running    <= 1'b0;
      push_valid <= 1'b0;
      drop_count <= '0;
    end else begin
      running <= 1'b1;
      if (accept && !is_drop) begin
        push_valid <= 1'b1;
      end else if (push_ready) begin
        push_valid <= 1'b0;
      end
      if (accept && is_drop) begin
        drop_count <= drop_count + 16'd1;  // Reads and BAR 6/7 end here.
      end
    end
  end

  always_ff @(posedge m_axi_aclk) begin
    if (accept && !is_drop) begin
      push_req.addr <= axi_addr;
      push_req.strb <= mem_req.byte_enable;
      push_req.data <= mem_req.write_data;
    end
  end

  // A stalled output must not change under the FIFO.
  a_push_stable : assert property (
    @(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
    push_valid && !push_ready |=> push_valid && $stable(push_req)
  ) else $error("push_req changed while stalled");

endmodule

// ==== verilog/write_request_fifo.sv ====
`timescale 1ns/100ps

module write_request_fifo
  import pcie_axi_pkg::*;
#(
  parameter int FIFO_DEPTH = 4
) (
  input  logic        m_axi_aclk,
  input  logic        m_axi_aresetn,

  input  axi_wr_req_t push_req,
  input  logic        push_valid,
  output logic        push_ready,

  output axi_wr_req_t pop_req,
  output logic        pop_valid,
  input  logic        pop_ready
);

  localparam int AW = $clog2(FIFO_DEPTH);

  if (FIFO_DEPTH < 2 || (FIFO_DEPTH & (FIFO_DEPTH - 1)) != 0) begin : g_depth_check
    $error("FIFO_DEPTH must be a power of two and at least 2");
  end

  axi_wr_req_t mem [FIFO_DEPTH];

  // The extra top bit flips on every wrap so full and empty differ.
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic [AW:0] fill_level;
  logic        full;
  logic        empty;
  logic        push;
  logic        pop;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

  assign fill_level = wr_ptr - rd_ptr;  // Modulo the pointer width, so wraps count right.

  assign push_ready = !full;
  assign pop_valid  = !empty;
  assign pop_req    = mem[rd_ptr[AW-1:0]];

  assign push = push_valid && push_ready;
  assign pop  = pop_valid && pop_ready;

  always_ff @(posedge m_axi_aclk) begin
    if (!m_axi_aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge m_axi_aclk) begin
    if (push) begin
      mem[wr_ptr[AW-1:0]] <= push_req;
    end
  end

  // Occupancy can never run past the storage, whatever the decoder does.
  a_no_overflow : assert property (
    @(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
    fill_level <= FIFO_DEPTH
  ) else $error("FIFO overflow");

  a_no_underflow : assert property (
    @(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
    pop_ready |-> pop_valid
  ) else $error("pop requested from an empty FIFO");

endmodule

// ==== verilog/axi_write_controller.sv ====
`timescale 1ns/100ps

module axi_write_controller
  import pcie_axi_pkg::*;
(
  input  logic        m_axi_aclk,
  input  logic        m_axi_aresetn,

  input  axi_wr_req_t pop_req,
  input  logic        pop_valid,
  output logic        pop_ready,

  output logic [31:0] m_axi_awaddr,
  output logic [2:0]  m_axi_awprot,
  output logic        m_axi_awvalid,
  input  logic        m_axi_awready,

  output logic [31:0] m_axi_wdata,
  output logic [3:0]  m_axi_wstrb,
  output logic        m_axi_wvalid,
  input  logic        m_axi_wready,

  input  logic [1:0]  m_axi_bresp,
  input  logic        m_axi_bvalid,
  output logic        m_axi_bready,

  output logic [7:0]  bresp_err_count
);

  localparam logic [2:0] ST_IDLE = 3'b001;
  localparam logic [2:0] ST_ADDR = 3'b010;
  localparam logic [2:0] ST_DATA = 3'b100;

  logic [2:0]  state;
  axi_wr_req_t req_q;
  logic        resp_err;

  // Each valid is simply its state bit, so it is registered and holds until ready.
  assign m_axi_awvalid = state[1];
  assign m_axi_wvalid  = state[2];
  assign pop_ready     = state[0] && pop_valid;

  assign m_axi_awaddr = req_q.addr;
  assign m_axi_awprot = 3'b000;
  assign m_axi_wdata  = req_q.data;
  assign m_axi_wstrb  = req_q.strb;
  assign m_axi_bready = 1'b1;

  assign resp_err = m_axi_bvalid && (m_axi_bresp != RESP_OKAY);

  always_ff @(posedge m_axi_aclk) begin
    if (!m_axi_aresetn) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (pop_valid) begin
            state <= ST_ADDR;
          end
        end
        ST_ADDR: begin
          if (m_axi_awready) begin
            state <= ST_DATA;
          end
        end
        ST_DATA: begin
          if (m_axi_wready) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge m_axi_aclk) begin
    if (pop_ready) begin
      req_q <= pop_req;  // Held for both the AW and the W phase.
    end
  end

  // Errors are only counted; the write is not retried.
  always_ff @(posedge m_axi_aclk) begin
    if (!m_axi_aresetn) begin
      bresp_err_count <= '0;
    end else if (resp_err && bresp_err_count != 8'hff) begin
      bresp_err_count <= bresp_err_count + 8'd1;
    end
  end

  a_aw_w_exclusive : assert property (
    @(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
    !(m_axi_awvalid && m_axi_wvalid)
  ) else $error("awvalid and wvalid high together");

  a_awaddr_stable : assert property (
    @(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
    m_axi_awvalid && !m_axi_awready |=> m_axi_awvalid && $stable(m_axi_awaddr)
  ) else $error("awaddr changed while awvalid waited");

endmodule

// ==== verilog/pcie_axi_write_bridge.sv ====
`timescale 1ns/100ps

module pcie_axi_write_bridge
  import pcie_axi_pkg::*;
#(
  parameter bar_base_t BAR_BASE   = {32'h4500_0000, 32'h4400_0000, 32'h4300_0000,
                                     32'h4200_0000, 32'h4100_0000, 32'h4000_0000},
  parameter bar_size_t BAR_SIZE   = {6{5'd12}},
  parameter int        FIFO_DEPTH = 4
) (
  input  logic        m_axi_aclk,
  input  logic        m_axi_aresetn,

  input  mem_req_t    mem_req,
  input  logic        mem_req_valid,
  output logic        mem_req_ready,

  output logic [31:0] m_axi_awaddr,
  output logic [2:0]  m_axi_awprot,
  output logic        m_axi_awvalid,
  input  logic        m_axi_awready,

  output logic [31:0] m_axi_wdata,
  output logic [3:0]  m_axi_wstrb,
  output logic        m_axi_wvalid,
  input  logic        m_axi_wready,

  input  logic [1:0]  m_axi_bresp,
  input  logic        m_axi_bvalid,
  output logic        m_axi_bready,

  output logic [15:0] drop_count,
  output logic [7:0]  bresp_err_count
);

  axi_wr_req_t push_req;
  logic        push_valid;
  logic        push_ready;
  axi_wr_req_t pop_req;
  logic        pop_valid;
  logic        pop_ready;

  bar_request_decoder #(
    .BAR_BASE (BAR_BASE),
    .BAR_SIZE (BAR_SIZE)
  ) u_decoder (
    .m_axi_aclk    (m_axi_aclk),
    .m_axi_aresetn (m_axi_aresetn),
    .mem_req       (mem_req),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .push_req      (push_req),
    .push_valid    (push_valid),
    .push_ready    (push_ready),
    .drop_count    (drop_count)
  );

  write_request_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .m_axi_aclk    (m_axi_aclk),
    .m_axi_aresetn (m_axi_aresetn),
    .push_req      (push_req),
    .push_valid    (push_valid),
    .push_ready    (push_ready),
    .pop_req       (pop_req),
    .pop_valid     (pop_valid),
    .pop_ready     (pop_ready)
  );

  axi_write_controller u_controller (
    .m_axi_aclk      (m_axi_aclk),
    .m_axi_aresetn   (m_axi_aresetn),
    .pop_req         (pop_req),
    .pop_valid       (pop_valid),
    .pop_ready       (pop_ready),
    .m_axi_awaddr    (m_axi_awaddr),
    .m_axi_awprot    (m_axi_awprot),
    .m_axi_awvalid   (m_axi_awvalid),
    .m_axi_awready   (m_axi_awready),
    .m_axi_wdata     (m_axi_wdata),
    .m_axi_wstrb     (m_axi_wstrb),
    .m_axi_wvalid    (m_axi_wvalid),
    .m_axi_wready    (m_axi_wready),
    .m_axi_bresp     (m_axi_bresp),
    .m_axi_bvalid    (m_axi_bvalid),
    .m_axi_bready    (m_axi_bready),
    .bresp_err_count (bresp_err_count)
  );

endmodule

// ==== dv/axi_lite_slave_model.sv ====
`timescale 1ns/100ps

module axi_lite_slave_model
  import pcie_axi_pkg::*;
#(
  parameter int          LOG_DEPTH = 64,
  parameter logic [31:0] SEED      = 32'h1863_7adb
) (
  input  logic        m_axi_aclk,
  input  logic        m_axi_aresetn,

  input  logic [31:0] m_axi_awaddr,
  input  logic [2:0]  m_axi_awprot,
  input  logic        m_axi_awvalid,
  output logic        m_axi_awready,

  input  logic [31:0] m_axi_wdata,
  input  logic [3:0]  m_axi_wstrb,
  input  logic        m_axi_wvalid,
  output logic        m_axi_wready,

  output logic [1:0]  m_axi_bresp,
  output logic        m_axi_bvalid,
  input  logic        m_axi_bready,

  input  logic        hold_awready,
  input  logic [31:0] err_base,
  input  logic [31:0] err_mask
);

  logic [31:0] rng_state;
  logic [31:0] aw_addr_q;
  logic        aw_pending;    // An address was taken and its data has not come yet.
  axi_wr_req_t w_entry;
  axi_wr_req_t log_mem [LOG_DEPTH];
  int          log_count;
  int          protocol_errors;

  function automatic logic [31:0] next_random(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  assign w_entry = {aw_addr_q, m_axi_wstrb, m_axi_wdata};

  always @(posedge m_axi_aclk) begin
    if (!m_axi_aresetn) begin
      rng_state       <= SEED;
      m_axi_awready   <= 1'b0;
      m_axi_wready    <= 1'b0;
      m_axi_bvalid    <= 1'b0;
      m_axi_bresp     <= RESP_OKAY;
      aw_addr_q       <= '0;
      aw_pending      <= 1'b0;
      log_count       <= 0;
      protocol_errors <= 0;
    end else begin
      rng_state <= next_random(rng_state);
      // The low bits of an LCG repeat with a short period, so stalls use the top bits.
      m_axi_awready <= !hold_awready && rng_state[31];
      m_axi_wready  <= rng_state[30] || rng_state[29];

      if (m_axi_awvalid && m_axi_awprot != 3'b000) begin
        protocol_errors <= protocol_errors + 1;
        $display("Slave model: awprot is not zero at %0t", $time);
      end

      if (m_axi_awvalid && m_axi_awready) begin
        aw_addr_q  <= m_axi_awaddr;
        aw_pending <= 1'b1;
      end

      if (m_axi_wvalid && m_axi_wready) begin
        if (!aw_pending) begin
          protocol_errors <= protocol_errors + 1;
          $display("Slave model: write data arrived before its address at %0t", $time);
        end
        if (log_count < LOG_DEPTH) begin
          log_mem[log_count] <= w_entry;
        end
        log_count    <= log_count + 1;
        aw_pending   <= 1'b0;
        m_axi_bvalid <= 1'b1;
        // Writes into the error window are answered with SLVERR.
        m_axi_bresp  <= ((aw_addr_q & ~err_mask) == err_base) ? RESP_SLVERR : RESP_OKAY;
      end else if (m_axi_bready) begin
        m_axi_bvalid <= 1'b0;
      end
    end
  end

endmodule

// ==== dv/tb_pcie_axi_write.sv ====
`timescale 1ns/100ps

module tb_pcie_axi_write
  import pcie_axi_pkg::*;
();

  localparam int DRIVE_DELAY   = 10;
  localparam int RESET_CYCLES  = 16;
  localparam int READY_TIMEOUT = 200;
  localparam int DRAIN_TIMEOUT = 2000;
  localparam int STALL_CYCLES  = 30;    // How long awready is held low once the front end stalls.
  localparam int MAX_WORDS     = 1024;
  localparam int HEADER_WORDS  = 3;
  localparam int REQ_WORDS     = 8;

  localparam bar_base_t TB_BAR_BASE = {32'h7000_0000, 32'h6000_0a00, 32'h4300_0000,
                                       32'h4200_0000, 32'h5010_0000, 32'h4000_0000};
  localparam bar_size_t TB_BAR_SIZE = {5'd16, 5'd8, 5'd12, 5'd12, 5'd20, 5'd12};

  logic        m_axi_aclk;
  logic        m_axi_aresetn;
  mem_req_t    mem_req;
  logic        mem_req_valid;
  logic        mem_req_ready;
  logic [31:0] m_axi_awaddr;
  logic [2:0]  m_axi_awprot;
  logic        m_axi_awvalid;
  logic        m_axi_awready;
  logic [31:0] m_axi_wdata;
  logic [3:0]  m_axi_wstrb;
  logic        m_axi_wvalid;
  logic        m_axi_wready;
  logic [1:0]  m_axi_bresp;
  logic        m_axi_bvalid;
  logic        m_axi_bready;
  logic [15:0] drop_count;
  logic [7:0]  bresp_err_count;

  logic        hold_awready;
  logic [31:0] err_base;
  logic [31:0] err_mask;
  logic        saw_stall;
  int          stall_cycles;

  logic [31:0] test_words [MAX_WORDS];
  axi_wr_req_t expected_q [$];
  mem_req_t    next_req;
  int          num_reqs;
  int          expected_drops;
  int          expected_errs;
  int          mismatch_count;
  int          timeout_count;
  int          other_count;

  pcie_axi_write_bridge #(
    .BAR_BASE   (TB_BAR_BASE),
    .BAR_SIZE   (TB_BAR_SIZE),
    .FIFO_DEPTH (4)
  ) UUT (
    .m_axi_aclk      (m_axi_aclk),
    .m_axi_aresetn   (m_axi_aresetn),
    .mem_req         (mem_req),
    .mem_req_valid   (mem_req_valid),
    .mem_req_ready   (mem_req_ready),
    .m_axi_awaddr    (m_axi_awaddr),
    .m_axi_awprot    (m_axi_awprot),
    .m_axi_awvalid   (m_axi_awvalid),
    .m_axi_awready   (m_axi_awready),
    .m_axi_wdata     (m_axi_wdata),
    .m_axi_wstrb     (m_axi_wstrb),
    .m_axi_wvalid    (m_axi_wvalid),
    .m_axi_wready    (m_axi_wready),
    .m_axi_bresp     (m_axi_bresp),
    .m_axi_bvalid    (m_axi_bvalid),
    .m_axi_bready    (m_axi_bready),
    .drop_count      (drop_count),
    .bresp_err_count (bresp_err_count)
  );

  axi_lite_slave_model #(
    .SEED (32'h1863_7adb)
  ) u_slave (
    .m_axi_aclk    (m_axi_aclk),
    .m_axi_aresetn (m_axi_aresetn),
    .m_axi_awaddr  (m_axi_awaddr),
    .m_axi_awprot  (m_axi_awprot),
    .m_axi_awvalid (m_axi_awvalid),
    .m_axi_awready (m_axi_awready),
    .m_axi_wdata   (m_axi_wdata),
    .m_axi_wstrb   (m_axi_wstrb),
    .m_axi_wvalid  (m_axi_wvalid),
    .m_axi_wready  (m_axi_wready),
    .m_axi_bresp   (m_axi_bresp),
    .m_axi_bvalid  (m_axi_bvalid),
    .m_axi_bready  (m_axi_bready),
    .hold_awready  (hold_awready),
    .err_base      (err_base),
    .err_mask      (err_mask)
  );

  initial begin
    m_axi_aclk = 1'b0;
    forever #50 m_axi_aclk = ~m_axi_aclk;
  end

  // Release the AW stall once the front end has been held off long enough.
  always @(negedge m_axi_aclk) begin
    if (hold_awready && mem_req_valid && !mem_req_ready) begin
      saw_stall    <= 1'b1;
      stall_cycles <= stall_cycles + 1;
      if (stall_cycles >= STALL_CYCLES) begin
        hold_awready <= 1'b0;
      end
    end
  end

  task automatic report_mismatch(input string msg);
    $display("FAILED at %0d ns: %s", $time, msg);
    mismatch_count++;
  endtask

  task automatic check_reset_state();
    if (mem_req_ready !== 1'b1) report_mismatch("mem_req_ready low on first cycle after reset");
    if (m_axi_awvalid !== 1'b0) report_mismatch("awvalid high after reset");
    if (m_axi_wvalid !== 1'b0) report_mismatch("wvalid high after reset");
    if (drop_count !== 16'd0) report_mismatch("drop_count not zero after reset");
    if (bresp_err_count !== 8'd0) report_mismatch("bresp_err_count not zero after reset");
  endtask

  // Builds request idx from the data file and records what the AXI side should see.
  task automatic prepare_request(input int idx, output mem_req_t req);
    int          base;
    axi_wr_req_t exp;
    base             = HEADER_WORDS + idx * REQ_WORDS;
    req.bar_hit      = test_words[base][2:0];
    req.pcie_address = test_words[base + 1];
    req.byte_enable  = test_words[base + 2][3:0];
    req.write_readn  = test_words[base + 3][0];
    req.phys_func    = test_words[base + 4][0];
    req.write_data   = test_words[base + 5];
    exp.addr         = test_words[base + 6];
    exp.strb         = req.byte_enable;
    exp.data         = req.write_data;
    if (test_words[base + 7][0]) begin
      expected_drops++;
    end else begin
      expected_q.push_back(exp);
      if ((exp.addr & ~err_mask) == err_base) begin
        expected_errs++;
      end
    end
  endtask

  // Called a short delay after a rising edge; ready is stable until the next edge.
  task automatic send_request(input int idx, input mem_req_t req);
    int waited;
    waited        = 0;
    mem_req       = req;
    mem_req_valid = 1'b1;
    while (!mem_req_ready && waited < READY_TIMEOUT) begin
      @(posedge m_axi_aclk);
      #DRIVE_DELAY;
      waited++;
    end
    if (!mem_req_ready) begin
      $display("Timeout: mem_req_ready stayed low for %0d cycles at request %0d", waited, idx);
      timeout_count++;
    end else begin
      @(posedge m_axi_aclk);
      #DRIVE_DELAY;
    end
    mem_req_valid = 1'b0;
  endtask

  task automatic wait_for_drain(input int n);
    int waited;
    waited = 0;
    while (!(u_slave.log_count >= n && !m_axi_bvalid && !m_axi_awvalid && !m_axi_wvalid)
           && waited < DRAIN_TIMEOUT) begin
      @(posedge m_axi_aclk);
      #DRIVE_DELAY;
      waited++;
    end
    if (u_slave.log_count < n || m_axi_bvalid || m_axi_awvalid || m_axi_wvalid) begin
      $display("Timeout: only %0d of %0d AXI writes finished after %0d cycles",
               u_slave.log_count, n, waited);
      timeout_count++;
    end
  endtask

  task automatic check_write_log();
    axi_wr_req_t got;
    axi_wr_req_t exp;
    int          n;
    if (u_slave.log_count != expected_q.size()) begin
      report_mismatch($sformatf("%0d AXI writes, expected %0d",
                                u_slave.log_count, expected_q.size()));
    end
    n = (u_slave.log_count < expected_q.size()) ? u_slave.log_count : expected_q.size();
    for (int i = 0; i < n; i++) begin
      got = u_slave.log_mem[i];
      exp = expected_q[i];
      if (got.addr !== exp.addr) begin
        report_mismatch($sformatf("write %0d addr %h, expected %h", i, got.addr, exp.addr));
      end
      if (got.strb !== exp.strb) begin
        report_mismatch($sformatf("write %0d strb %h, expected %h", i, got.strb, exp.strb));
      end
      if (got.data !== exp.data) begin
        report_mismatch($sformatf("write %0d data %h, expected %h", i, got.data, exp.data));
      end
    end
  endtask

  task automatic check_counters();
    if (drop_count !== expected_drops) begin
      report_mismatch($sformatf("drop_count %0d, expected %0d", drop_count, expected_drops));
    end
    if (bresp_err_count !== expected_errs) begin
      report_mismatch($sformatf("bresp_err_count %0d, expected %0d",
                                bresp_err_count, expected_errs));
    end
    if (!saw_stall) begin
      $display("mem_req_ready never went low while awready was held low");
      other_count++;
    end
    if (u_slave.protocol_errors != 0) begin
      $display("The slave model saw %0d AXI protocol errors", u_slave.protocol_errors);
      other_count++;
    end
  endtask

  initial begin
    m_axi_aresetn  = 1'b0;
    mem_req        = '0;
    mem_req_valid  = 1'b0;
    hold_awready   = 1'b0;
    err_base       = '0;
    err_mask       = '0;
    saw_stall      = 1'b0;
    stall_cycles   = 0;
    num_reqs       = 0;
    expected_drops = 0;
    expected_errs  = 0;
    mismatch_count = 0;
    timeout_count  = 0;
    other_count    = 0;

    $readmemh("dv/pcie_axi_testdata.txt", test_words);
    if ($isunknown(test_words[2]) || test_words[2] == 0
        || HEADER_WORDS + test_words[2] * REQ_WORDS > MAX_WORDS) begin
      $display("The data file header is missing or gives a bad request count");
      other_count++;
    end else begin
      err_base = test_words[0];
      err_mask = test_words[1];
      num_reqs = test_words[2];
      if ($isunknown(test_words[HEADER_WORDS + num_reqs * REQ_WORDS - 1])) begin
        $display("The data file holds fewer requests than its header says");
        other_count++;
        num_reqs = 0;
      end
    end

    repeat (RESET_CYCLES) @(posedge m_axi_aclk);
    #DRIVE_DELAY;
    if (mem_req_ready !== 1'b0) report_mismatch("mem_req_ready high during reset");
    m_axi_aresetn = 1'b1;
    @(posedge m_axi_aclk);
    #DRIVE_DELAY;
    check_reset_state();

    hold_awready = 1'b1;  // Start with a long AW stall so the front end backs up.
    for (int i = 0; i < num_reqs && timeout_count == 0; i++) begin
      prepare_request(i, next_req);
      send_request(i, next_req);
    end

    if (num_reqs > 0 && timeout_count == 0) begin
      wait_for_drain(expected_q.size());
      check_write_log();
      check_counters();
    end

    $display("Errors: %0d mismatches, %0d timeouts, %0d other",
             mismatch_count, timeout_count, other_count);
    if (mismatch_count == 0 && timeout_count == 0 && other_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== pcie_axi_write.f ====
verilog/pcie_axi_pkg.sv
verilog/bar_request_decoder.sv
verilog/write_request_fifo.sv
verilog/axi_write_controller.sv
verilog/pcie_axi_write_bridge.sv
dv/axi_lite_slave_model.sv
dv/tb_pcie_axi_write.sv

// ==== Bender.yml ====
package:
  name: pcie_axi_write

sources:
  - verilog/pcie_axi_pkg.sv
  - verilog/bar_request_decoder.sv
  - verilog/write_request_fifo.sv
  - verilog/axi_write_controller.sv
  - verilog/pcie_axi_write_bridge.sv
  - target: test
    files:
      - dv/axi_lite_slave_model.sv
      - dv/tb_pcie_axi_write.sv

// ==== dv/pcie_axi_testdata.txt ====
// Header: slave error window base, error window mask, number of requests.
// Request: bar_hit pcie_address byte_enable write_readn phys_func write_data
//          expected_axi_addr drop (1 for reads and BAR 6/7, which make no AXI write)
42000000 00000fff 00000016
0 00000010 f 1 0 a5a50001 40000010 0
0 12345678 3 1 0 00000102 40000678 0
1 000abcd4 f 1 1 deadbeef 501abcd4 0
2 00000020 f 1 0 11112222 42000020 0
3 ffff0ffe c 1 0 33334444 43000ffc 0
4 00000133 1 1 0 55556666 60000a30 0
5 0001fffc f 1 0 77778888 7000fffc 0
0 00000040 f 0 0 00000000 00000000 1
6 00000044 f 1 0 99990000 00000000 1
7 00000048 f 1 0 99990001 00000000 1
2 00000ffc 8 1 0 cafef00d 42000ffc 0
1 fffffff8 f 1 0 0badf00d 501ffff8 0
3 00000004 6 1 1 abcdef01 43000004 0
5 00000000 f 0 1 00000000 00000000 1
4 000000ff 2 1 0 13572468 60000afc 0
0 00000800 f 1 0 24681357 40000800 0
2 00001000 f 1 0 feedface 42000000 0
0 00000abc 1 1 0 00000011 40000abc 0
1 00000003 f 1 0 00000022 50100000 0
3 00000104 f 1 0 00000033 43000104 0
5 00012344 f 1 0 00000044 70002344 0
7 00000000 f 0 0 00000000 00000000 1
